/* common/fb_pkg.sv */
`default_nettype none

package fb_pkg;

  // axi-lite write path widths
  localparam int AXIL_DATA_W = 16;
  localparam int AXIL_STRB_W = 2;

  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

  typedef logic [15:0] pixel_t;
  typedef logic [11:0] color_t;
  typedef logic [19:0] fb_addr_t;
  typedef logic [9:0]  coord_t;
  typedef logic [1:0]  cfg_addr_t;

  typedef enum logic [1:0] {
    PAT_SOLID   = 2'd0,
    PAT_VSTRIPE = 2'd1,
    PAT_HSTRIPE = 2'd2,
    PAT_CHECKER = 2'd3
  } pattern_kind_e;

  typedef struct packed {
    pattern_kind_e kind;
    logic [2:0]    shift;
    color_t        fg;
    color_t        bg;
  } pattern_cfg_t;

  // register map
  localparam cfg_addr_t REG_CTRL   = 2'd0;
  localparam cfg_addr_t REG_FG     = 2'd1;
  localparam cfg_addr_t REG_BG     = 2'd2;
  localparam cfg_addr_t REG_STATUS = 2'd3;

  // ctrl fields: start [0], kind [2:1], shift [5:3]
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_KIND_LSB  = 1;
  localparam int CTRL_SHIFT_LSB = 3;

  // status fields
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  typedef struct packed {
    fb_addr_t awaddr;
    logic     awvalid;
  } axil_aw_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] wdata;
    logic [AXIL_STRB_W-1:0] wstrb;
    logic                   wvalid;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] bresp;
    logic       bvalid;
  } axil_b_t;

  typedef enum logic {
    IDLE    = 1'b0,
    WRITING = 1'b1
  } gen_state_e;

endpackage

`default_nettype wire

/* verilog/fb_pattern_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_pattern_regs (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              cfg_we,
  input  wire fb_pkg::cfg_addr_t cfg_addr,
  input  wire logic [15:0]       cfg_wdata,
  input  wire logic              busy,
  input  wire logic              done,
  output logic [15:0]            cfg_rdata,
  output logic                   start,
  output fb_pkg::pattern_cfg_t   pattern_cfg
);

  fb_pkg::pattern_kind_e kind_q;
  logic [2:0]            shift_q;
  fb_pkg::color_t        fg_q;
  fb_pkg::color_t        bg_q;
  logic                  done_q;
  logic                  ctrl_wr;

  assign ctrl_wr = cfg_we && (cfg_addr == fb_pkg::REG_CTRL);

  always_ff @(posedge clk) begin
    if (reset) begin
      kind_q  <= fb_pkg::PAT_SOLID;
      shift_q <= 3'd0;
      fg_q    <= '0;
      bg_q    <= '0;
    end else if (cfg_we) begin
      case (cfg_addr)
        fb_pkg::REG_CTRL: begin
          // fields update even while a fill runs
          kind_q  <= fb_pkg::pattern_kind_e'(cfg_wdata[fb_pkg::CTRL_KIND_LSB +: 2]);
          shift_q <= cfg_wdata[fb_pkg::CTRL_SHIFT_LSB +: 3];
        end
        fb_pkg::REG_FG: fg_q <= cfg_wdata[11:0];
        fb_pkg::REG_BG: bg_q <= cfg_wdata[11:0];
        default: ;
      endcase
    end
  end

  // start pulse, dropped while busy or while a start is already in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= ctrl_wr && cfg_wdata[fb_pkg::CTRL_START_BIT] && !busy && !start;
    end
  end

  // sticky done, cleared by the next accepted start
  always_ff @(posedge clk) begin
    if (reset) begin
      done_q <= 1'b0;
    end else if (start) begin
      done_q <= 1'b0;
    end else if (done) begin
      done_q <= 1'b1;
    end
  end

  assign pattern_cfg = '{kind: kind_q, shift: shift_q, fg: fg_q, bg: bg_q};

  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      fb_pkg::REG_CTRL: begin
        cfg_rdata[fb_pkg::CTRL_KIND_LSB +: 2]  = kind_q;
        cfg_rdata[fb_pkg::CTRL_SHIFT_LSB +: 3] = shift_q;
      end
      fb_pkg::REG_FG: cfg_rdata[11:0] = fg_q;
      fb_pkg::REG_BG: cfg_rdata[11:0] = bg_q;
      fb_pkg::REG_STATUS: begin
        cfg_rdata[fb_pkg::STATUS_BUSY_BIT] = busy;
        cfg_rdata[fb_pkg::STATUS_DONE_BIT] = done_q;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* pattern_gen/vga_sram_pattern_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_sram_pattern_generator #(
  parameter int h_pixels = 640,
  parameter int v_pixels = 480
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 start,
  input  wire fb_pkg::pattern_cfg_t pattern_cfg,
  input  wire logic                 awready,
  input  wire logic                 wready,
  input  wire fb_pkg::axil_b_t      b,
  output fb_pkg::axil_aw_t          aw,
  output fb_pkg::axil_w_t           w,
  output logic                      bready,
  output logic                      busy,
  output logic                      done
);

  fb_pkg::gen_state_e   state;
  fb_pkg::gen_state_e   next_state;
  fb_pkg::pattern_cfg_t cfg_q;
  fb_pkg::pattern_cfg_t cfg_use;
  fb_pkg::coord_t       row;
  fb_pkg::coord_t       column;
  fb_pkg::coord_t       row_nxt;
  fb_pkg::coord_t       column_nxt;
  logic                 last_column;
  logic                 last_pixel;
  logic                 write_start;
  logic                 write_done;

  // pattern rule on the shifted coordinates
  function automatic fb_pkg::pixel_t pattern_pixel(fb_pkg::pattern_cfg_t cfg,
                                                   fb_pkg::coord_t r,
                                                   fb_pkg::coord_t c);
    fb_pkg::coord_t r_s;
    fb_pkg::coord_t c_s;
    logic           use_fg;
    r_s = r >> cfg.shift;
    c_s = c >> cfg.shift;
    case (cfg.kind)
      fb_pkg::PAT_VSTRIPE: use_fg = !c_s[0];
      fb_pkg::PAT_HSTRIPE: use_fg = !r_s[0];
      fb_pkg::PAT_CHECKER: use_fg = (r_s[0] == c_s[0]);
      default:             use_fg = 1'b1;
    endcase
    return {(use_fg ? cfg.fg : cfg.bg), 4'b0000};
  endfunction

  assign write_done  = bready && b.bvalid;
  assign last_column = (column == fb_pkg::coord_t'(h_pixels - 1));
  assign last_pixel  = last_column && (row == fb_pkg::coord_t'(v_pixels - 1));

  // coordinates of the write about to be issued
  always_comb begin
    if (state == fb_pkg::IDLE) begin
      row_nxt    = '0;
      column_nxt = '0;
    end else if (last_column) begin
      row_nxt    = row + 1'b1;
      column_nxt = '0;
    end else begin
      row_nxt    = row;
      column_nxt = column + 1'b1;
    end
  end

  // first write of a fill sees the config before it is latched
  assign cfg_use = (state == fb_pkg::IDLE) ? pattern_cfg : cfg_q;

  always_comb begin
    next_state  = state;
    write_start = 1'b0;
    case (state)
      fb_pkg::IDLE: begin
        if (start) begin
          write_start = 1'b1;
          next_state  = fb_pkg::WRITING;
        end
      end
      fb_pkg::WRITING: begin
        if (write_done) begin
          if (last_pixel) begin
            next_state = fb_pkg::IDLE;
          end else begin
            write_start = 1'b1;
          end
        end
      end
      default: next_state = fb_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fb_pkg::IDLE;
      done  <= 1'b0;
    end else begin
      state <= next_state;
      done  <= (state == fb_pkg::WRITING) && write_done && last_pixel;
    end
  end

  always_ff @(posedge clk) begin
    if (state == fb_pkg::IDLE && start) begin
      cfg_q <= pattern_cfg;
    end
    if (write_start) begin
      row    <= row_nxt;
      column <= column_nxt;
    end
  end

  // axi-lite write channels, one write outstanding
  always_ff @(posedge clk) begin
    if (reset) begin
      aw.awvalid <= 1'b0;
      w.wvalid   <= 1'b0;
      bready     <= 1'b0;
    end else begin
      bready <= 1'b1;
      if (write_start) begin
        aw.awvalid <= 1'b1;
        w.wvalid   <= 1'b1;
      end else begin
        if (awready && aw.awvalid) begin
          aw.awvalid <= 1'b0;
        end
        if (wready && w.wvalid) begin
          w.wvalid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_start) begin
      aw.awaddr <= fb_pkg::fb_addr_t'(row_nxt) * fb_pkg::fb_addr_t'(h_pixels)
                   + fb_pkg::fb_addr_t'(column_nxt);
      w.wdata   <= pattern_pixel(cfg_use, row_nxt, column_nxt);
      w.wstrb   <= '1;
    end
  end

  assign busy = (state == fb_pkg::WRITING);

endmodule

`default_nettype wire

/* sram/sram_axil_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_axil_writer #(
  parameter int depth = 307200
) (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire fb_pkg::axil_aw_t aw,
  input  wire fb_pkg::axil_w_t  w,
  input  wire logic             bready,
  input  wire fb_pkg::fb_addr_t rd_addr,
  output logic                  awready,
  output logic                  wready,
  output fb_pkg::axil_b_t       b,
  output fb_pkg::pixel_t        rd_data
);

  localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

  fb_pkg::pixel_t   mem [depth];
  logic             aw_held;
  logic             w_held;
  logic             bvalid_q;
  fb_pkg::fb_addr_t addr_q;
  fb_pkg::pixel_t   data_q;
  logic             mem_we;

  // no new beats accepted while a response is pending
  assign awready = !aw_held && !bvalid_q;
  assign wready  = !w_held && !bvalid_q;
  assign mem_we  = aw_held && w_held;

  always_ff @(posedge clk) begin
    if (reset) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (mem_we) begin
        aw_held  <= 1'b0;
        w_held   <= 1'b0;
        bvalid_q <= 1'b1;
      end else begin
        if (aw.awvalid && awready) begin
          aw_held <= 1'b1;
        end
        if (w.wvalid && wready) begin
          w_held <= 1'b1;
        end
      end
      if (bvalid_q && bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // channel payloads
  always_ff @(posedge clk) begin
    if (aw.awvalid && awready) begin
      addr_q <= aw.awaddr;
    end
    if (w.wvalid && wready) begin
      // only full-word strobes are expected
      data_q <= w.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[addr_q[idx_w-1:0]] <= data_q;
    end
  end

  // scan-out stand-in
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr[idx_w-1:0]];
  end

  assign b = '{bresp: fb_pkg::AXIL_RESP_OKAY, bvalid: bvalid_q};

endmodule

`default_nettype wire

/* verilog/fb_fill_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_fill_top #(
  parameter int h_pixels = 640,
  parameter int v_pixels = 480
) (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              cfg_we,
  input  wire fb_pkg::cfg_addr_t cfg_addr,
  input  wire logic [15:0]       cfg_wdata,
  input  wire fb_pkg::fb_addr_t  rd_addr,
  output logic [15:0]            cfg_rdata,
  output fb_pkg::pixel_t         rd_data
);

  fb_pkg::pattern_cfg_t pattern_cfg;
  logic                 start;
  logic                 busy;
  logic                 done;

  // generator to sram write path
  fb_pkg::axil_aw_t     aw;
  fb_pkg::axil_w_t      w;
  fb_pkg::axil_b_t      b;
  logic                 awready;
  logic                 wready;
  logic                 bready;

  fb_pattern_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .busy       (busy),
    .done       (done),
    .cfg_rdata  (cfg_rdata),
    .start      (start),
    .pattern_cfg(pattern_cfg)
  );

  vga_sram_pattern_generator #(
    .h_pixels(h_pixels),
    .v_pixels(v_pixels)
  ) u_gen (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .pattern_cfg(pattern_cfg),
    .awready    (awready),
    .wready     (wready),
    .b          (b),
    .aw         (aw),
    .w          (w),
    .bready     (bready),
    .busy       (busy),
    .done       (done)
  );

  sram_axil_writer #(
    .depth(h_pixels * v_pixels)
  ) u_sram (
    .clk    (clk),
    .reset  (reset),
    .aw     (aw),
    .w      (w),
    .bready (bready),
    .rd_addr(rd_addr),
    .awready(awready),
    .wready (wready),
    .b      (b),
    .rd_data(rd_data)
  );

endmodule

`default_nettype wire

/* dv/fb_fill_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_fill_tb;

  localparam int h_pixels = 16;
  localparam int v_pixels = 12;
  localparam int frame    = h_pixels * v_pixels;
  localparam int case_w   = 6;

  logic              clk;
  logic              reset;
  logic              cfg_we;
  fb_pkg::cfg_addr_t cfg_addr;
  logic [15:0]       cfg_wdata;
  fb_pkg::fb_addr_t  rd_addr;
  logic [15:0]       cfg_rdata;
  fb_pkg::pixel_t    rd_data;

  logic [15:0] pat [64];
  int          n_cases;
  int          corner_base;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] rng;

  fb_fill_top #(
    .h_pixels(h_pixels),
    .v_pixels(v_pixels)
  ) uut (
    .clk      (clk),
    .reset    (reset),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .rd_addr  (rd_addr),
    .cfg_rdata(cfg_rdata),
    .rd_data  (rd_data)
  );

  always #50 clk = ~clk;

  // run limit scales with the number of cases in the file
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: no result after %0d clock cycles", cycle_count);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // expected pixel from the pattern rule on the address
  function automatic logic [15:0] expected_pixel(input logic [1:0] kind, input logic [2:0] shift,
                                                 input logic [11:0] fg, input logic [11:0] bg,
                                                 input int addr);
    int   band_r;
    int   band_c;
    logic pick_fg;
    band_r = (addr / h_pixels) >> shift;
    band_c = (addr % h_pixels) >> shift;
    case (kind)
      2'd0:    pick_fg = 1'b1;
      2'd1:    pick_fg = (band_c % 2) == 0;
      2'd2:    pick_fg = (band_r % 2) == 0;
      default: pick_fg = (band_r % 2) == (band_c % 2);
    endcase
    return pick_fg ? {fg, 4'h0} : {bg, 4'h0};
  endfunction

  function automatic logic [15:0] ctrl_word(input logic [1:0] kind, input logic [2:0] shift,
                                            input logic go);
    return {10'b0, shift, kind, go};
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic reg_write(input fb_pkg::cfg_addr_t a, input logic [15:0] d);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    next_cycle();
    cfg_we    = 1'b0;
  endtask

  task automatic reg_read(input fb_pkg::cfg_addr_t a, output logic [15:0] d);
    cfg_addr = a;
    next_cycle();
    d = cfg_rdata;
  endtask

  task automatic pixel_read(input int a, output logic [15:0] d);
    rd_addr = fb_pkg::fb_addr_t'(a);
    next_cycle();
    d = rd_data;
  endtask

  // busy in status bit 0 and done in bit 1
  task automatic start_fill(input logic [1:0] kind, input logic [2:0] shift);
    logic [15:0] st;
    reg_write(fb_pkg::REG_CTRL, ctrl_word(kind, shift, 1'b1));
    reg_read(fb_pkg::REG_STATUS, st);
    check_value(st[1:0], 2'b01, "status just after start");
  endtask

  task automatic wait_done;
    logic [15:0] st;
    do begin
      reg_read(fb_pkg::REG_STATUS, st);
    end while (!st[1]);
    check_value(st[1:0], 2'b10, "status after fill");
  endtask

  // whole frame when count reaches the frame size, otherwise random picks and corners
  task automatic check_frame(input int idx, input logic [1:0] kind, input logic [2:0] shift,
                             input logic [11:0] fg, input logic [11:0] bg, input int count);
    int          a;
    int          n;
    logic [15:0] px;
    n = (count >= frame) ? frame : count + 4;
    for (int i = 0; i < n; i++) begin
      if (count >= frame) begin
        a = i;
      end else if (i < count) begin
        rng = xorshift32(rng);
        a   = rng % frame;
      end else begin
        a = pat[corner_base + i - count];
      end
      pixel_read(a, px);
      check_value(px, expected_pixel(kind, shift, fg, bg, a),
                  $sformatf("case %0d pixel %0d", idx, a));
    end
  endtask

  initial begin
    int          base;
    int          count;
    logic [1:0]  kind;
    logic [2:0]  shift;
    logic [11:0] fg;
    logic [11:0] bg;
    logic        twist;
    logic [1:0]  kind_mid;
    logic [2:0]  shift_mid;
    logic [15:0] st;
    clk         = 1'b0;
    reset       = 1'b1;
    cfg_we      = 1'b0;
    cfg_addr    = fb_pkg::REG_CTRL;
    cfg_wdata   = '0;
    rd_addr     = '0;
    rng         = 32'd20;
    cycle_count = 0;
    $readmemh("dv/fill_patterns.txt", pat);
    n_cases     = pat[0];
    corner_base = 1 + n_cases * case_w;
    cycle_limit = n_cases * (frame * 4 + 200);
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    reg_read(fb_pkg::REG_STATUS, st);
    check_value(st[1:0], 2'b00, "status after reset");
    reg_read(fb_pkg::REG_FG, st);
    check_value(st, 16'h0000, "fg after reset");

    for (int c = 0; c < n_cases; c++) begin
      base  = 1 + c * case_w;
      kind  = pat[base][1:0];
      shift = pat[base + 1][2:0];
      fg    = pat[base + 2][11:0];
      bg    = pat[base + 3][11:0];
      count = pat[base + 4];
      twist = pat[base + 5][0];
      reg_write(fb_pkg::REG_FG, {4'h0, fg});
      reg_write(fb_pkg::REG_BG, {4'h0, bg});
      start_fill(kind, shift);
      if (twist) begin
        // new colours, kind and shift with a second start in the middle of the fill
        kind_mid  = ~kind;
        shift_mid = shift + 3'd1;
        reg_write(fb_pkg::REG_FG, {4'h0, ~fg});
        reg_write(fb_pkg::REG_BG, {4'h0, ~bg});
        reg_write(fb_pkg::REG_CTRL, ctrl_word(kind_mid, shift_mid, 1'b1));
        reg_read(fb_pkg::REG_STATUS, st);
        check_value(st[1:0], 2'b01, "status after start while busy");
        reg_read(fb_pkg::REG_CTRL, st);
        check_value(st[5:1], {shift_mid, kind_mid}, "ctrl fields written during fill");
      end
      wait_done();
      check_frame(c, kind, shift, fg, bg, count);
      if (twist) begin
        reg_read(fb_pkg::REG_FG, st);
        check_value(st, {4'h0, ~fg}, "fg written during fill");
        reg_read(fb_pkg::REG_BG, st);
        check_value(st, {4'h0, ~bg}, "bg written during fill");
        start_fill(kind, shift);
        wait_done();
        check_frame(c, kind, shift, ~fg, ~bg, count);
      end
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/fill_patterns.txt */
// first word: number of cases; then one line per case: kind shift fg bg samples flag
// kind 0 solid 1 vstripe 2 hstripe 3 checker; samples c0 reads the whole frame
// flag 1 adds a start while busy and a colour change during the fill
8
0 0 f00 00f 8 0
1 0 0f0 123 a 0
1 1 abc 456 a 0
2 2 789 fed a 1
2 0 321 cba 8 0
3 1 fff 000 c0 0
3 0 5a5 a5a c 0
3 2 e1c 3d7 10 0
// corner addresses, checked after every sampled case
0 f b0 bf

/* list.f */
common/fb_pkg.sv
verilog/fb_pattern_regs.sv
pattern_gen/vga_sram_pattern_generator.sv
sram/sram_axil_writer.sv
verilog/fb_fill_top.sv
dv/fb_fill_tb.sv

/* Makefile */
# Verilator simulation of the frame buffer fill subsystem

VERILATOR ?= verilator
TOP       ?= fb_fill_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
